// File: pipe_trace_top.f
verilog/pipe_trace_pkg.sv
verilog/trace_ctrl.sv
verilog/trace_id_pipe.sv
verilog/trace_record_store.sv
verilog/trace_retire.sv
verilog/pipe_trace_top.sv
sim/pipe_trace_sva.sv
sim/pipe_trace_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pipe trace testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module pipe_trace_tb \
    -f pipe_trace_top.f

# An aborted run counts as a failure in the log
./obj_dir/Vpipe_trace_tb > sim.log 2>&1 || echo "sim failed" >> sim.log
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

// File: sim/pipe_trace_sva.sv
`timescale 1ns/100ps

module pipe_trace_sva (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      stall,
    input logic                      fetch_valid,
    input logic                      decode_valid,
    input logic                      execute_valid,
    input pipe_trace_pkg::hold_cnt_t hold_val      // Count of the entry in decode
);

    // A stalled cycle always leaves a bubble in execute
    a_exec_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !execute_valid)
        else $error("execute valid after a stalled cycle");

    // Fetch is live from the first cycle out of reset on
    a_fetch_live: assert property (@(posedge clk) disable iff (!rst_n)
        rst_n |=> fetch_valid)
        else $error("fetch valid low after start");

    // A saturated count stays put while the stall goes on
    a_hold_limit: assert property (@(posedge clk) disable iff (!rst_n)
        (decode_valid && stall && hold_val == pipe_trace_pkg::HOLD_MAX)
        |=> (hold_val == pipe_trace_pkg::HOLD_MAX))
        else $error("hold count left its limit");

endmodule

// Store sees the stall, the valids and the hold array
bind trace_record_store pipe_trace_sva u_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (stall),
    .fetch_valid   (fetch_valid),
    .decode_valid  (decode_valid),
    .execute_valid (execute_valid),
    .hold_val      (hold_mem[decode_id])
);

// File: sim/pipe_trace_tb.sv
`timescale 1ns/100ps

module pipe_trace_tb;

    localparam int ID_W      = 4;        // 16 records, IDs wrap quickly
    localparam int DRAIN_CYC = 10;       // Back end empties in 3
    localparam int SLACK_CYC = 30;

    logic clk = 1'b0;
    logic rst_n;
    logic stall;
    pipe_trace_pkg::stage_code_t fetch_code;
    pipe_trace_pkg::stage_code_t decode_code;
    pipe_trace_pkg::instr_word_t instr_word;
    pipe_trace_pkg::stage_code_t execute_code;
    pipe_trace_pkg::stage_code_t mem_code;
    pipe_trace_pkg::stage_code_t wb_code;

    logic                        retire_valid;
    logic [ID_W-1:0]             retire_id;
    pipe_trace_pkg::instr_word_t retire_instr;
    pipe_trace_pkg::stage_code_t retire_fetch_code;
    pipe_trace_pkg::stage_code_t retire_decode_code;
    pipe_trace_pkg::hold_cnt_t   retire_hold;
    pipe_trace_pkg::stage_code_t retire_execute_code;
    pipe_trace_pkg::stage_code_t retire_mem_code;
    pipe_trace_pkg::stage_code_t retire_wb_code;

    logic [79:0] stim_q[$];              // {stall, fetch, decode, instr, execute, mem, wb}
    logic [87:0] exp_q[$];               // {id, instr, fetch, decode, hold, execute, mem, wb}
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;

    pipe_trace_top #(.ID_W(ID_W)) u_dut (
        .clk (clk), .rst_n (rst_n), .stall (stall),
        .fetch_code (fetch_code), .decode_code (decode_code), .instr_word (instr_word),
        .execute_code (execute_code), .mem_code (mem_code), .wb_code (wb_code),
        .retire_valid (retire_valid), .retire_id (retire_id), .retire_instr (retire_instr),
        .retire_fetch_code (retire_fetch_code), .retire_decode_code (retire_decode_code),
        .retire_hold (retire_hold), .retire_execute_code (retire_execute_code),
        .retire_mem_code (retire_mem_code), .retire_wb_code (retire_wb_code)
    );

    always #10 clk = ~clk;               // 20 ns period

    task automatic stop_failed();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare(input string field, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %h, expected %h", $time, field, got, exp);
            stop_failed();
        end
    endtask

    //////////////////////////////
    // Trace file
    //////////////////////////////

    task automatic load_trace();
        int               fd;
        logic [7:0]       tag;
        logic [7:0]       s, f, d, h, e, m, w, id;
        logic [31:0]      iw;
        logic [8*160-1:0] line;
        fd = $fopen("sim/pipe_trace_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file sim/pipe_trace_trace.txt");
            stop_failed();
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            if (tag == "#") begin
                void'($fgets(line, fd));     // Column notes
            end else if (tag == "C") begin
                if ($fscanf(fd, "%h %h %h %h %h %h %h", s, f, d, iw, e, m, w) != 7) begin
                    $display("a stimulus row in the trace file is incomplete");
                    stop_failed();
                end
                stim_q.push_back({s, f, d, iw, e, m, w});
            end else if (tag == "R") begin
                if ($fscanf(fd, "%h %h %h %h %h %h %h %h", id, iw, f, d, h, e, m, w) != 8) begin
                    $display("an expected retire row in the trace file is incomplete");
                    stop_failed();
                end
                exp_q.push_back({id, iw, f, d, h, e, m, w});
            end else begin
                $display("the trace file holds a row of unknown type");
                stop_failed();
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_row(input logic [79:0] row);
        stall        <= row[72];
        fetch_code   <= row[71:64];
        decode_code  <= row[63:56];
        instr_word   <= row[55:24];
        execute_code <= row[23:16];
        mem_code     <= row[15:8];
        wb_code      <= row[7:0];
    endtask

    //////////////////////////////
    // Retire checking
    //////////////////////////////

    task automatic check_retire();
        logic [87:0] exp;
        if (exp_q.size() == 0) begin
            $display("a retire pulse came with no expected record left");
            stop_failed();
        end
        exp = exp_q.pop_front();
        compare("retire_id", 32'(retire_id), 32'(exp[87:80]));
        compare("retire_instr", retire_instr, exp[79:48]);
        compare("retire_fetch_code", 32'(retire_fetch_code), 32'(exp[47:40]));
        compare("retire_decode_code", 32'(retire_decode_code), 32'(exp[39:32]));
        compare("retire_hold", 32'(retire_hold), 32'(exp[31:24]));
        compare("retire_execute_code", 32'(retire_execute_code), 32'(exp[23:16]));
        compare("retire_mem_code", 32'(retire_mem_code), 32'(exp[15:8]));
        compare("retire_wb_code", 32'(retire_wb_code), 32'(exp[7:0]));
    endtask

    // Outputs settle between edges, sample on the falling edge
    always @(negedge clk) begin
        if (!rst_n && retire_valid === 1'b1) begin
            $display("retire pulse seen while reset was held");
            stop_failed();
        end else if (rst_n && retire_valid) begin
            check_retire();
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout, the run did not end within %0d cycles", cycle_limit);
            stop_failed();
        end
    end

    initial begin
        rst_n        = 1'b0;
        stall        = 1'b0;
        fetch_code   = '0;
        decode_code  = '0;
        instr_word   = '0;
        execute_code = '0;
        mem_code     = '0;
        wb_code      = '0;
        load_trace();
        cycle_limit = stim_q.size() + SLACK_CYC;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        foreach (stim_q[i]) begin
            @(posedge clk);
            drive_row(stim_q[i]);        // Row 0 lands in the first cycle out of reset
        end
        repeat (DRAIN_CYC) begin
            @(posedge clk);
            drive_row({8'h01, 72'h0});   // Front end held, back end drains
        end
        @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected retire records never arrived", exp_q.size());
            stop_failed();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// File: sim/pipe_trace_trace.txt
# C stall fetch_code decode_code instr_word execute_code mem_code wb_code (hex, one per cycle)
# R id instr fetch_code decode_code hold execute_code mem_code wb_code (hex, in retire order)
C 0 00 40 a0000000 80 c0 00
C 0 01 41 a0000001 81 c1 01
C 0 02 42 a0000002 82 c2 02
C 1 03 43 a0000003 83 c3 03
C 1 04 44 a0000004 84 c4 04
C 0 05 45 a0000005 85 c5 05
C 0 06 46 a0000006 86 c6 06
C 1 07 47 a0000007 87 c7 07
C 1 08 48 a0000008 88 c8 08
C 1 09 49 a0000009 89 c9 09
C 1 0a 4a a000000a 8a ca 0a
C 1 0b 4b a000000b 8b cb 0b
C 1 0c 4c a000000c 8c cc 0c
C 1 0d 4d a000000d 8d cd 0d
C 1 0e 4e a000000e 8e ce 0e
C 1 0f 4f a000000f 8f cf 0f
C 1 10 50 a0000010 90 d0 10
C 1 11 51 a0000011 91 d1 11
C 1 12 52 a0000012 92 d2 12
C 1 13 53 a0000013 93 d3 13
C 1 14 54 a0000014 94 d4 14
C 1 15 55 a0000015 95 d5 15
C 1 16 56 a0000016 96 d6 16
C 0 17 57 a0000017 97 d7 17
C 0 18 58 a0000018 98 d8 18
C 0 19 59 a0000019 99 d9 19
C 0 1a 5a a000001a 9a da 1a
C 0 1b 5b a000001b 9b db 1b
C 0 1c 5c a000001c 9c dc 1c
C 0 1d 5d a000001d 9d dd 1d
C 0 1e 5e a000001e 9e de 1e
C 0 1f 5f a000001f 9f df 1f
C 0 20 60 a0000020 a0 e0 20
C 0 21 61 a0000021 a1 e1 21
C 0 22 62 a0000022 a2 e2 22
C 0 23 63 a0000023 a3 e3 23
C 1 24 64 a0000024 a4 e4 24
C 1 25 65 a0000025 a5 e5 25
C 1 26 66 a0000026 a6 e6 26
R 0 a0000001 00 41 0 82 c3 04
R 1 a0000002 01 42 0 83 c4 05
R 2 a0000005 02 45 2 86 c7 08
R 3 a0000006 05 46 0 87 c8 09
R 4 a0000017 06 57 f 98 d9 1a
R 5 a0000018 17 58 0 99 da 1b
R 6 a0000019 18 59 0 9a db 1c
R 7 a000001a 19 5a 0 9b dc 1d
R 8 a000001b 1a 5b 0 9c dd 1e
R 9 a000001c 1b 5c 0 9d de 1f
R a a000001d 1c 5d 0 9e df 20
R b a000001e 1d 5e 0 9f e0 21
R c a000001f 1e 5f 0 a0 e1 22
R d a0000020 1f 60 0 a1 e2 23
R e a0000021 20 61 0 a2 e3 24
R f a0000022 21 62 0 a3 e4 25
R 0 a0000023 22 63 0 a4 e5 26

// File: verilog/pipe_trace_pkg.sv
package pipe_trace_pkg;

    //////////////////////////////
    // Record field widths
    //////////////////////////////

    // Event code from one pipeline stage
    typedef logic [7:0]  stage_code_t;

    // Raw instruction word as seen in decode
    typedef logic [31:0] instr_word_t;

    // Stalled cycles spent in decode
    typedef logic [3:0]  hold_cnt_t;

    // Hold count sticks here, never wraps
    localparam hold_cnt_t HOLD_MAX = 4'd15;

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    // RUN while the front end moves, HOLD after a sampled stall
    typedef enum logic {
        CTRL_RUN  = 1'b0,
        CTRL_HOLD = 1'b1
    } ctrl_state_t;

endpackage

// File: verilog/pipe_trace_top.sv
`timescale 1ns/100ps

module pipe_trace_top #(
    parameter int ID_W = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  pipe_trace_pkg::stage_code_t fetch_code,
    input  pipe_trace_pkg::stage_code_t decode_code,
    input  pipe_trace_pkg::instr_word_t instr_word,
    input  pipe_trace_pkg::stage_code_t execute_code,
    input  pipe_trace_pkg::stage_code_t mem_code,
    input  pipe_trace_pkg::stage_code_t wb_code,
    output logic                        retire_valid,
    output logic [ID_W-1:0]             retire_id,
    output pipe_trace_pkg::instr_word_t retire_instr,
    output pipe_trace_pkg::stage_code_t retire_fetch_code,
    output pipe_trace_pkg::stage_code_t retire_decode_code,
    output pipe_trace_pkg::hold_cnt_t   retire_hold,
    output pipe_trace_pkg::stage_code_t retire_execute_code,
    output pipe_trace_pkg::stage_code_t retire_mem_code,
    output pipe_trace_pkg::stage_code_t retire_wb_code
);

    //////////////////////////////
    // Control to datapath
    //////////////////////////////

    logic fetch_valid, decode_valid, execute_valid, mem_valid, wb_valid;
    logic advance;
    logic fetch_new;

    logic [ID_W-1:0] fetch_id, decode_id, execute_id, mem_id, wb_id;

    // Record at the write-back ID
    pipe_trace_pkg::instr_word_t rd_instr;
    pipe_trace_pkg::stage_code_t rd_fetch_code;
    pipe_trace_pkg::stage_code_t rd_decode_code;
    pipe_trace_pkg::hold_cnt_t   rd_hold;
    pipe_trace_pkg::stage_code_t rd_execute_code;
    pipe_trace_pkg::stage_code_t rd_mem_code;

    trace_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .fetch_valid   (fetch_valid),
        .decode_valid  (decode_valid),
        .execute_valid (execute_valid),
        .mem_valid     (mem_valid),
        .wb_valid      (wb_valid),
        .advance       (advance),
        .fetch_new     (fetch_new)
    );

    trace_id_pipe #(.ID_W(ID_W)) u_id_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .fetch_id   (fetch_id),
        .decode_id  (decode_id),
        .execute_id (execute_id),
        .mem_id     (mem_id),
        .wb_id      (wb_id)
    );

    //////////////////////////////
    // Record capture and retire
    //////////////////////////////

    trace_record_store #(.ID_W(ID_W)) u_store (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .fetch_valid     (fetch_valid),
        .fetch_new       (fetch_new),
        .decode_valid    (decode_valid),
        .execute_valid   (execute_valid),
        .mem_valid       (mem_valid),
        .fetch_id        (fetch_id),
        .decode_id       (decode_id),
        .execute_id      (execute_id),
        .mem_id          (mem_id),
        .fetch_code      (fetch_code),
        .decode_code     (decode_code),
        .instr_word      (instr_word),
        .execute_code    (execute_code),
        .mem_code        (mem_code),
        .wb_id           (wb_id),
        .rd_instr        (rd_instr),
        .rd_fetch_code   (rd_fetch_code),
        .rd_decode_code  (rd_decode_code),
        .rd_hold         (rd_hold),
        .rd_execute_code (rd_execute_code),
        .rd_mem_code     (rd_mem_code)
    );

    trace_retire #(.ID_W(ID_W)) u_retire (
        .clk                 (clk),
        .rst_n               (rst_n),
        .wb_valid            (wb_valid),
        .wb_id               (wb_id),
        .wb_code             (wb_code),
        .rd_instr            (rd_instr),
        .rd_fetch_code       (rd_fetch_code),
        .rd_decode_code      (rd_decode_code),
        .rd_hold             (rd_hold),
        .rd_execute_code     (rd_execute_code),
        .rd_mem_code         (rd_mem_code),
        .retire_valid        (retire_valid),
        .retire_id           (retire_id),
        .retire_instr        (retire_instr),
        .retire_fetch_code   (retire_fetch_code),
        .retire_decode_code  (retire_decode_code),
        .retire_hold         (retire_hold),
        .retire_execute_code (retire_execute_code),
        .retire_mem_code     (retire_mem_code),
        .retire_wb_code      (retire_wb_code)
    );

endmodule

// File: verilog/trace_ctrl.sv
`timescale 1ns/100ps

module trace_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic stall,          // Front end held this cycle
    output logic fetch_valid,
    output logic decode_valid,
    output logic execute_valid,
    output logic mem_valid,
    output logic wb_valid,
    output logic advance,        // Stages moved into this cycle
    output logic fetch_new       // First cycle of an ID in fetch
);

    pipe_trace_pkg::ctrl_state_t state;

    //////////////////////////////
    // State and front-end flags
    //////////////////////////////

    // Reset parks the FSM in HOLD so advance stays low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= pipe_trace_pkg::CTRL_HOLD;
            fetch_valid <= 1'b0;
            fetch_new   <= 1'b0;
        end else if (!fetch_valid) begin
            // First edge out of reset, ID 0 lands in fetch without a shift
            state       <= pipe_trace_pkg::CTRL_HOLD;
            fetch_valid <= 1'b1;
            fetch_new   <= 1'b1;
        end else begin
            state       <= stall ? pipe_trace_pkg::CTRL_HOLD : pipe_trace_pkg::CTRL_RUN;
            fetch_new   <= !stall;           // New ID only when fetch moved on
        end
    end

    assign advance = (state == pipe_trace_pkg::CTRL_RUN); // Flop driven

    //////////////////////////////
    // Valid chain
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decode_valid  <= 1'b0;
            execute_valid <= 1'b0;
            mem_valid     <= 1'b0;
            wb_valid      <= 1'b0;
        end else if (fetch_valid) begin
            if (!stall) begin
                decode_valid <= fetch_valid;    // Decode keeps its valid through a hold
            end
            execute_valid <= decode_valid && !stall; // Bubble on stalled cycles
            mem_valid     <= execute_valid;      // Back end never stalls
            wb_valid      <= mem_valid;
        end
    end

endmodule

// File: verilog/trace_id_pipe.sv
`timescale 1ns/100ps

module trace_id_pipe #(
    parameter int ID_W = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            advance,     // Stages shifted into this cycle
    output logic [ID_W-1:0] fetch_id,
    output logic [ID_W-1:0] decode_id,
    output logic [ID_W-1:0] execute_id,
    output logic [ID_W-1:0] mem_id,
    output logic [ID_W-1:0] wb_id
);

    // Stage IDs of the previous cycle
    logic [ID_W-1:0] fetch_q;            // Also the wrapping ID counter
    logic [ID_W-1:0] decode_q;
    logic [ID_W-1:0] execute_q;
    logic [ID_W-1:0] mem_q;

    //////////////////////////////
    // History registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_q   <= '0;             // First fetch ID is 0
            decode_q  <= '0;
            execute_q <= '0;
            mem_q     <= '0;
        end else begin
            fetch_q   <= fetch_id;
            decode_q  <= decode_id;
            execute_q <= execute_id;
            mem_q     <= mem_id;
        end
    end

    //////////////////////////////
    // Current stage IDs
    //////////////////////////////

    // Counter steps only when fetch moved on, wraps at 2**ID_W
    assign fetch_id   = advance ? fetch_q + ID_W'(1) : fetch_q;

    // Decode holds with fetch
    assign decode_id  = advance ? fetch_q : decode_q;

    // Back half shifts every cycle, execute ID is a bubble when held
    assign execute_id = decode_q;
    assign mem_id     = execute_q;
    assign wb_id      = mem_q;

endmodule

// File: verilog/trace_record_store.sv
`timescale 1ns/100ps

module trace_record_store #(
    parameter int ID_W = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        fetch_valid,
    input  logic                        fetch_new,
    input  logic                        decode_valid,
    input  logic                        execute_valid,
    input  logic                        mem_valid,
    input  logic [ID_W-1:0]             fetch_id,
    input  logic [ID_W-1:0]             decode_id,
    input  logic [ID_W-1:0]             execute_id,
    input  logic [ID_W-1:0]             mem_id,
    input  pipe_trace_pkg::stage_code_t fetch_code,
    input  pipe_trace_pkg::stage_code_t decode_code,
    input  pipe_trace_pkg::instr_word_t instr_word,
    input  pipe_trace_pkg::stage_code_t execute_code,
    input  pipe_trace_pkg::stage_code_t mem_code,
    input  logic [ID_W-1:0]             wb_id,
    output pipe_trace_pkg::instr_word_t rd_instr,
    output pipe_trace_pkg::stage_code_t rd_fetch_code,
    output pipe_trace_pkg::stage_code_t rd_decode_code,
    output pipe_trace_pkg::hold_cnt_t   rd_hold,
    output pipe_trace_pkg::stage_code_t rd_execute_code,
    output pipe_trace_pkg::stage_code_t rd_mem_code
);

    localparam int DEPTH = 2 ** ID_W;    // One record per live ID

    //////////////////////////////
    // Record arrays
    //////////////////////////////

    pipe_trace_pkg::stage_code_t fetch_mem   [DEPTH];
    pipe_trace_pkg::stage_code_t decode_mem  [DEPTH];
    pipe_trace_pkg::instr_word_t instr_mem   [DEPTH];
    pipe_trace_pkg::hold_cnt_t   hold_mem    [DEPTH];
    pipe_trace_pkg::stage_code_t execute_mem [DEPTH];
    pipe_trace_pkg::stage_code_t mem_mem     [DEPTH];

    // Held decode entry is below the limit
    logic hold_inc;

    assign hold_inc = decode_valid && stall
                   && (hold_mem[decode_id] != pipe_trace_pkg::HOLD_MAX);

    // Front end writes, latest code wins while the stage is valid
    always_ff @(posedge clk) begin
        if (rst_n) begin
            if (fetch_valid) begin
                fetch_mem[fetch_id] <= fetch_code;
            end
            if (fetch_new) begin
                // Fresh ID, wipe what the last lap left behind
                decode_mem[fetch_id]  <= '0;
                instr_mem[fetch_id]   <= '0;
                hold_mem[fetch_id]    <= '0;
                execute_mem[fetch_id] <= '0;
                mem_mem[fetch_id]     <= '0;
            end
            if (decode_valid) begin
                decode_mem[decode_id] <= decode_code;
                instr_mem[decode_id]  <= instr_word;
            end
            if (hold_inc) begin
                hold_mem[decode_id] <= hold_mem[decode_id] + 4'd1; // Saturates
            end
            if (execute_valid) begin
                execute_mem[execute_id] <= execute_code;
            end
            if (mem_valid) begin
                mem_mem[mem_id] <= mem_code;
            end
        end
    end

    //////////////////////////////
    // Write-back read port
    //////////////////////////////

    // Combinational, retire registers it
    assign rd_instr        = instr_mem[wb_id];
    assign rd_fetch_code   = fetch_mem[wb_id];
    assign rd_decode_code  = decode_mem[wb_id];
    assign rd_hold         = hold_mem[wb_id];
    assign rd_execute_code = execute_mem[wb_id];
    assign rd_mem_code     = mem_mem[wb_id];

endmodule

// File: verilog/trace_retire.sv
`timescale 1ns/100ps

module trace_retire #(
    parameter int ID_W = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wb_valid,
    input  logic [ID_W-1:0]             wb_id,
    input  pipe_trace_pkg::stage_code_t wb_code,     // Live from the write-back stage
    input  pipe_trace_pkg::instr_word_t rd_instr,
    input  pipe_trace_pkg::stage_code_t rd_fetch_code,
    input  pipe_trace_pkg::stage_code_t rd_decode_code,
    input  pipe_trace_pkg::hold_cnt_t   rd_hold,
    input  pipe_trace_pkg::stage_code_t rd_execute_code,
    input  pipe_trace_pkg::stage_code_t rd_mem_code,
    output logic                        retire_valid,
    output logic [ID_W-1:0]             retire_id,
    output pipe_trace_pkg::instr_word_t retire_instr,
    output pipe_trace_pkg::stage_code_t retire_fetch_code,
    output pipe_trace_pkg::stage_code_t retire_decode_code,
    output pipe_trace_pkg::hold_cnt_t   retire_hold,
    output pipe_trace_pkg::stage_code_t retire_execute_code,
    output pipe_trace_pkg::stage_code_t retire_mem_code,
    output pipe_trace_pkg::stage_code_t retire_wb_code
);

    //////////////////////////////
    // Retire strobe
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_valid;    // One pulse per write-back cycle
        end
    end

    // Record fields, hold between pulses
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            retire_id           <= wb_id;
            retire_instr        <= rd_instr;
            retire_fetch_code   <= rd_fetch_code;
            retire_decode_code  <= rd_decode_code;
            retire_hold         <= rd_hold;
            retire_execute_code <= rd_execute_code;
            retire_mem_code     <= rd_mem_code;
            retire_wb_code      <= wb_code;  // Not stored, taken straight from the stage
        end
    end

endmodule
